// File: hdl/jpeg_dht_pkg.sv
/* Sizes and types shared by the DHT table unit:
   code length limits, table index, length index and the selector byte view */
package jpeg_dht_pkg;

    // ------------------------------------------------------------------
    // Limits fixed by baseline JPEG
    // ------------------------------------------------------------------

    // Longest Huffman code, in bits
    localparam int DHT_MAX_LEN    = 16;

    // Width of a stored code and of the lookup window
    localparam int DHT_CODE_W     = 16;

    // Luma DC, luma AC, chroma DC, chroma AC
    localparam int DHT_NUM_TABLES = 4;

    // ------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------

    // 0 luma DC, 1 luma AC, 2 chroma DC, 3 chroma AC
    typedef logic [1:0] dht_tbl_t;

    // Code length minus one, 0 means a 1-bit code
    typedef logic [3:0] dht_len_t;

    // First byte of each table in the DHT segment
    // nib[1] is the class (0 DC, 1 AC), nib[0] the destination id
    typedef union packed
    {
        logic [7:0]      raw;
        logic [1:0][3:0] nib;
    } dht_sel_u;

endpackage

// File: hdl/dht_wr_if.sv
/* Code range write path from the DHT parser to the code table */
`timescale 1ns/1ps

interface dht_wr_if #(
    parameter int VALUE_ADDR_W = 10
);

    // One entry per cycle, taken by the table without a handshake
    logic                                   wr_valid;
    jpeg_dht_pkg::dht_tbl_t                 tbl;
    jpeg_dht_pkg::dht_len_t                 len;
    logic [jpeg_dht_pkg::DHT_CODE_W-1:0]    min_code;
    logic [jpeg_dht_pkg::DHT_CODE_W-1:0]    max_code;

    // First value slot of this length
    logic [VALUE_ADDR_W-1:0]                ptr;

    modport parser
    (
        output wr_valid, tbl, len, min_code, max_code, ptr
    );

    // Named code_tbl since "table" is a reserved word
    modport code_tbl
    (
        input  wr_valid, tbl, len, min_code, max_code, ptr
    );

endinterface

// File: hdl/dht_segment_parser.sv
/* DHT segment parser: walks selector, counts and symbols,
   generates canonical code ranges and allocates value slots */
`timescale 1ns/1ps

module dht_segment_parser #(
    parameter int VALUE_ADDR_W = 10
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    cfg_valid_i,
    input  logic [7:0]              cfg_data_i,
    input  logic                    cfg_last_i,
    output logic                    cfg_accept_o,
    dht_wr_if.parser                wr,
    output logic                    val_we_o,
    output logic [VALUE_ADDR_W-1:0] val_addr_o,
    output logic [7:0]              val_data_o
);

    localparam int MAX_LEN  = jpeg_dht_pkg::DHT_MAX_LEN;
    localparam int CODE_W   = jpeg_dht_pkg::DHT_CODE_W;
    localparam int LAST_LEN = MAX_LEN - 1;

    // Selector byte, then 16 counts, then symbols
    localparam logic [1:0] PH_SEL = 2'd0;
    localparam logic [1:0] PH_CNT = 2'd1;
    localparam logic [1:0] PH_SYM = 2'd2;

    logic [1:0]                 phase_q;
    jpeg_dht_pkg::dht_len_t     cnt_idx_q;
    jpeg_dht_pkg::dht_sel_u     sel_q;
    logic [7:0]                 count_q [MAX_LEN];
    logic [MAX_LEN-1:0]         has_q;
    logic [11:0]                total_q;
    logic [11:0]                seen_q;
    jpeg_dht_pkg::dht_len_t     len_q;
    logic [7:0]                 sym_j_q;
    logic [CODE_W-1:0]          code_q;
    logic [VALUE_ADDR_W-1:0]    alloc_q;

    logic                       fire_w;
    logic                       sym_fire_w;
    logic                       len_done_w;
    logic                       tbl_end_w;
    logic [11:0]                total_next_w;

    assign fire_w       = cfg_valid_i && cfg_accept_o;
    assign sym_fire_w   = fire_w && (phase_q == PH_SYM);
    assign len_done_w   = (sym_j_q + 8'd1) == count_q[len_q];
    assign tbl_end_w    = cfg_last_i || ((seen_q + 12'd1) == total_q);
    assign total_next_w = total_q + 12'(cfg_data_i);

    // Empty lengths are stepped over one per cycle with the byte held
    assign cfg_accept_o = (phase_q != PH_SYM) || has_q[len_q];

    // ------------------------------------------------------------------
    // Segment walk and canonical code generator
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            phase_q   <= PH_SEL;
            cnt_idx_q <= '0;
            has_q     <= '0;
            total_q   <= '0;
            seen_q    <= '0;
            len_q     <= '0;
            sym_j_q   <= '0;
            code_q    <= '0;
            alloc_q   <= '0;
        end
        else
        begin
            // Slots are shared by all tables and never rewind
            if (sym_fire_w)
                alloc_q <= alloc_q + 1'b1;

            case (phase_q)
                PH_SEL:
                begin
                    if (fire_w && !cfg_last_i)
                    begin
                        phase_q   <= PH_CNT;
                        cnt_idx_q <= '0;
                        total_q   <= '0;
                    end
                end
                PH_CNT:
                begin
                    if (fire_w)
                    begin
                        has_q[cnt_idx_q] <= (cfg_data_i != 8'd0);
                        total_q          <= total_next_w;
                        cnt_idx_q        <= cnt_idx_q + 1'b1;
                        len_q            <= '0;
                        sym_j_q          <= '0;
                        code_q           <= '0;
                        seen_q           <= '0;
                        if (cfg_last_i)
                            phase_q <= PH_SEL;
                        else if (cnt_idx_q == LAST_LEN)
                            phase_q <= (total_next_w == 12'd0) ? PH_SEL : PH_SYM;
                    end
                end
                PH_SYM:
                begin
                    if (fire_w)
                    begin
                        seen_q <= seen_q + 12'd1;
                        if (tbl_end_w)
                            phase_q <= PH_SEL;
                        if (len_done_w)
                        begin
                            sym_j_q <= '0;
                            len_q   <= len_q + 1'b1;
                            code_q  <= (code_q + 1'b1) << 1;
                        end
                        else
                        begin
                            sym_j_q <= sym_j_q + 8'd1;
                            code_q  <= code_q + 1'b1;
                        end
                    end
                    else if (!cfg_accept_o)
                    begin
                        // Empty length, no codes of this size
                        len_q  <= len_q + 1'b1;
                        code_q <= code_q << 1;
                    end
                end
                default:
                    phase_q <= PH_SEL;
            endcase
        end
    end

    // Selector and counts
    always_ff @(posedge clk_i)
    begin
        if (fire_w && (phase_q == PH_SEL))
            sel_q.raw <= cfg_data_i;
        if (fire_w && (phase_q == PH_CNT))
            count_q[cnt_idx_q] <= cfg_data_i;
    end

    // ------------------------------------------------------------------
    // Range writes
    // ------------------------------------------------------------------

    // A count byte clears its length, so a reload leaves no stale range
    assign wr.wr_valid = (fire_w && (phase_q == PH_CNT)) || (sym_fire_w && (sym_j_q == 8'd0));
    assign wr.tbl      = {sel_q.nib[0][0], sel_q.nib[1][0]};
    assign wr.len      = (phase_q == PH_CNT) ? cnt_idx_q : len_q;
    assign wr.min_code = (phase_q == PH_CNT) ? '0 : code_q;
    assign wr.max_code = (phase_q == PH_CNT) ? '0 : code_q + CODE_W'(count_q[len_q]);
    assign wr.ptr      = alloc_q;

    // Symbol memory write
    assign val_we_o   = sym_fire_w;
    assign val_addr_o = alloc_q;
    assign val_data_o = cfg_data_i;

endmodule

// File: hdl/dht_code_table.sv
/* Code range store for the four tables, shortest-length matcher
   and value address generation for the lookup path */
`timescale 1ns/1ps

module dht_code_table #(
    parameter int VALUE_ADDR_W = 10
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    dht_wr_if.code_tbl                          wr,
    input  logic                                lookup_req_i,
    input  jpeg_dht_pkg::dht_tbl_t              lookup_table_i,
    input  logic [jpeg_dht_pkg::DHT_CODE_W-1:0] lookup_input_i,
    output logic                                rd_valid_o,
    output logic [VALUE_ADDR_W-1:0]             rd_addr_o,
    output jpeg_dht_pkg::dht_len_t              rd_width_o
);

    localparam int NUM_TBL = jpeg_dht_pkg::DHT_NUM_TABLES;
    localparam int MAX_LEN = jpeg_dht_pkg::DHT_MAX_LEN;
    localparam int CODE_W  = jpeg_dht_pkg::DHT_CODE_W;

    // Per table and per length: first code, one past last code, first slot
    logic [CODE_W-1:0]          min_q [NUM_TBL][MAX_LEN];
    logic [CODE_W-1:0]          max_q [NUM_TBL][MAX_LEN];
    logic [VALUE_ADDR_W-1:0]    ptr_q [NUM_TBL][MAX_LEN];

    // ------------------------------------------------------------------
    // Range store
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int t = 0; t < NUM_TBL; t++)
            begin
                for (int l = 0; l < MAX_LEN; l++)
                begin
                    min_q[t][l] <= '0;
                    max_q[t][l] <= '0;
                    ptr_q[t][l] <= '0;
                end
            end
        end
        else if (wr.wr_valid)
        begin
            min_q[wr.tbl][wr.len] <= wr.min_code;
            max_q[wr.tbl][wr.len] <= wr.max_code;
            ptr_q[wr.tbl][wr.len] <= wr.ptr;
        end
    end

    // ------------------------------------------------------------------
    // Stage 1: match the shortest length
    // ------------------------------------------------------------------
    logic [CODE_W-1:0]          prefix_r;
    jpeg_dht_pkg::dht_len_t     width_r;

    // Walk from longest to shortest so the shortest hit wins
    always_comb
    begin
        width_r  = jpeg_dht_pkg::dht_len_t'(MAX_LEN - 1);
        prefix_r = '0;
        for (int l = MAX_LEN - 1; l >= 0; l--)
        begin
            prefix_r = lookup_input_i >> (MAX_LEN - 1 - l);
            if (prefix_r < max_q[lookup_table_i][l])
                width_r = jpeg_dht_pkg::dht_len_t'(l);
        end
    end

    logic                       valid_q;
    jpeg_dht_pkg::dht_len_t     width_q;
    jpeg_dht_pkg::dht_tbl_t     tbl_q;
    logic [CODE_W-1:0]          win_q;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            valid_q <= 1'b0;
        else
            valid_q <= lookup_req_i;
    end

    // Window is held per request so two lookups can overlap
    always_ff @(posedge clk_i)
    begin
        if (lookup_req_i)
        begin
            width_q <= width_r;
            tbl_q   <= lookup_table_i;
            win_q   <= lookup_input_i;
        end
    end

    // ------------------------------------------------------------------
    // Stage 2: value address
    // ------------------------------------------------------------------
    logic [CODE_W-1:0]  code_r;
    logic [CODE_W-1:0]  addr_r;

    always_comb
    begin
        // Right-align the matched prefix
        code_r = win_q >> (MAX_LEN - 1 - int'(width_q));
        addr_r = code_r - min_q[tbl_q][width_q] + CODE_W'(ptr_q[tbl_q][width_q]);
    end

    assign rd_valid_o = valid_q;
    assign rd_addr_o  = addr_r[VALUE_ADDR_W-1:0];
    assign rd_width_o = width_q;

endmodule

// File: hdl/dht_value_ram.sv
/* Symbol value memory with registered read and the output stage */
`timescale 1ns/1ps

module dht_value_ram #(
    parameter int VALUE_ADDR_W = 10
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    val_we_i,
    input  logic [VALUE_ADDR_W-1:0] val_addr_i,
    input  logic [7:0]              val_data_i,
    input  logic                    rd_valid_i,
    input  logic [VALUE_ADDR_W-1:0] rd_addr_i,
    input  jpeg_dht_pkg::dht_len_t  rd_width_i,
    output logic                    lookup_valid_o,
    output logic [4:0]              lookup_width_o,
    output logic [7:0]              lookup_value_o
);

    localparam int DEPTH = 2 ** VALUE_ADDR_W;

    // Block RAM, one write and one read port
    logic [7:0] mem_q [DEPTH];
    logic [7:0] value_q;
    logic [4:0] width_q;
    logic       valid_q;

    always_ff @(posedge clk_i)
    begin
        if (val_we_i)
            mem_q[val_addr_i] <= val_data_i;
    end

    // Length index 0..15 becomes a width of 1..16
    always_ff @(posedge clk_i)
    begin
        if (rd_valid_i)
        begin
            value_q <= mem_q[rd_addr_i];
            width_q <= {1'b0, rd_width_i} + 5'd1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            valid_q <= 1'b0;
        else
            valid_q <= rd_valid_i;
    end

    assign lookup_valid_o = valid_q;
    assign lookup_width_o = width_q;
    assign lookup_value_o = value_q;

endmodule

// File: hdl/jpeg_dht.sv
/* Writable JPEG Huffman table unit: parser, code table
   and value memory behind plain config and lookup ports */
`timescale 1ns/1ps

module jpeg_dht #(
    parameter int VALUE_ADDR_W = 10
) (
    input  logic        clk_i,
    input  logic        rst_i,

    // DHT segment body, one byte per transfer
    input  logic        cfg_valid_i,
    input  logic [7:0]  cfg_data_i,
    input  logic        cfg_last_i,
    output logic        cfg_accept_o,

    // Lookup, result two cycles after the request
    input  logic        lookup_req_i,
    input  logic [1:0]  lookup_table_i,
    input  logic [15:0] lookup_input_i,
    output logic        lookup_valid_o,
    output logic [4:0]  lookup_width_o,
    output logic [7:0]  lookup_value_o
);

    // ------------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------------
    dht_wr_if #(.VALUE_ADDR_W(VALUE_ADDR_W)) u_wr_if ();

    logic                       val_we_w;
    logic [VALUE_ADDR_W-1:0]    val_addr_w;
    logic [7:0]                 val_data_w;

    logic                       rd_valid_w;
    logic [VALUE_ADDR_W-1:0]    rd_addr_w;
    logic [3:0]                 rd_width_w;

    dht_segment_parser #(.VALUE_ADDR_W(VALUE_ADDR_W)) u_parser
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cfg_valid_i  (cfg_valid_i),
        .cfg_data_i   (cfg_data_i),
        .cfg_last_i   (cfg_last_i),
        .cfg_accept_o (cfg_accept_o),
        .wr           (u_wr_if.parser),
        .val_we_o     (val_we_w),
        .val_addr_o   (val_addr_w),
        .val_data_o   (val_data_w)
    );

    dht_code_table #(.VALUE_ADDR_W(VALUE_ADDR_W)) u_code_table
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .wr             (u_wr_if.code_tbl),
        .lookup_req_i   (lookup_req_i),
        .lookup_table_i (lookup_table_i),
        .lookup_input_i (lookup_input_i),
        .rd_valid_o     (rd_valid_w),
        .rd_addr_o      (rd_addr_w),
        .rd_width_o     (rd_width_w)
    );

    dht_value_ram #(.VALUE_ADDR_W(VALUE_ADDR_W)) u_value_ram
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .val_we_i       (val_we_w),
        .val_addr_i     (val_addr_w),
        .val_data_i     (val_data_w),
        .rd_valid_i     (rd_valid_w),
        .rd_addr_i      (rd_addr_w),
        .rd_width_i     (rd_width_w),
        .lookup_valid_o (lookup_valid_o),
        .lookup_width_o (lookup_width_o),
        .lookup_value_o (lookup_value_o)
    );

endmodule

// File: bench/jpeg_dht_asserts.sv
/* Bound checks on the DHT unit: lookup latency, width range,
   config back-pressure and reset values */
`timescale 1ns/1ps

module jpeg_dht_asserts
(
    input logic       clk_i,
    input logic       rst_i,
    input logic       cfg_valid_i,
    input logic       cfg_accept_o,
    input logic       lookup_req_i,
    input logic       lookup_valid_o,
    input logic [4:0] lookup_width_o
);

    // Number of failed assertions
    int fail_cnt = 0;

    // Result exactly two cycles after its request
    a_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        lookup_valid_o == $past(lookup_req_i, 2))
    else
    begin
        fail_cnt++;
        $error("lookup_valid_o does not follow lookup_req_i by two cycles");
    end

    a_width: assert property (@(posedge clk_i) disable iff (rst_i)
        lookup_valid_o |-> (lookup_width_o >= 5'd1 && lookup_width_o <= 5'd16))
    else
    begin
        fail_cnt++;
        $error("lookup width %0d outside 1 to 16", lookup_width_o);
    end

    // One stall cycle per skipped length, never two in a row
    a_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        (cfg_valid_i && !cfg_accept_o) |=> (cfg_accept_o || !cfg_valid_i))
    else
    begin
        fail_cnt++;
        $error("cfg_accept_o low for two cycles with a byte waiting");
    end

    a_reset: assert property (@(posedge clk_i)
        $fell(rst_i) |-> (cfg_accept_o && !lookup_valid_o))
    else
    begin
        fail_cnt++;
        $error("control outputs not at reset values after reset");
    end

endmodule

// File: bench/tb_jpeg_dht.sv
/* Testbench for the DHT table unit: clock and reset, xorshift tables,
   config stream, lookup stimulus, result queue and test report */
`timescale 1ns/1ps

module tb_jpeg_dht;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        cfg_valid_i;
    logic [7:0]  cfg_data_i;
    logic        cfg_last_i;
    logic        cfg_accept_o;
    logic        lookup_req_i;
    logic [1:0]  lookup_table_i;
    logic [15:0] lookup_input_i;
    logic        lookup_valid_o;
    logic [4:0]  lookup_width_o;
    logic [7:0]  lookup_value_o;

    // Table models: counts per length, symbols, canonical codes and lengths
    int          cnt_m  [4][16];
    int          nsym_m [4];
    logic [7:0]  sym_m  [4][64];
    int          code_m [4][64];
    int          len_m  [4][64];

    logic [31:0] rng_q = 32'h6d98980e;
    logic [4:0]  exp_w_q [$];
    logic [7:0]  exp_v_q [$];
    int          err_cnt = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          mark = 0;

    jpeg_dht #(.VALUE_ADDR_W(10)) DUT (.*);

    bind jpeg_dht jpeg_dht_asserts u_asserts (.*);

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        rng_q = rng_q ^ (rng_q << 13);
        rng_q = rng_q ^ (rng_q >> 17);
        rng_q = rng_q ^ (rng_q << 5);
        return rng_q;
    endfunction

    // ------------------------------------------------------------------
    // Table model
    // ------------------------------------------------------------------

    // Counts stay inside the code space; gaps mode empties every even length
    task automatic make_table(input int t, input bit gaps);
        int avail;
        int top;
        int code;
        int k;
        bit prev_empty;
        avail      = 2;
        top        = gaps ? 8 + int'(next_rand() % 9) : 3 + int'(next_rand() % 14);
        prev_empty = 1'b0;
        for (int l = 0; l < 16; l++)
        begin
            cnt_m[t][l] = 0;
            if (l < top)
            begin
                if (gaps ? (l % 2 == 0 && l < top - 1)
                         : (!prev_empty && l < top - 1 && next_rand() % 4 == 0))
                    cnt_m[t][l] = 0;
                else
                    cnt_m[t][l] = 1 + int'(next_rand() % ((avail - 1 < 4) ? avail - 1 : 4));
                prev_empty = (cnt_m[t][l] == 0);
                avail      = (avail - cnt_m[t][l]) * 2;
            end
        end
        // Canonical codes: consecutive per length, then (code + count) << 1
        code = 0;
        k    = 0;
        for (int l = 0; l < 16; l++)
        begin
            for (int j = 0; j < cnt_m[t][l]; j++)
            begin
                sym_m[t][k]  = 8'(next_rand());
                code_m[t][k] = code + j;
                len_m[t][k]  = l + 1;
                k++;
            end
            code = (code + cnt_m[t][l]) << 1;
        end
        nsym_m[t] = k;
    endtask

    // Empty lengths below the longest used one
    function automatic int skipped(input int t);
        int n;
        int top;
        n   = 0;
        top = 0;
        for (int l = 0; l < 16; l++)
            if (cnt_m[t][l] != 0)
                top = l;
        for (int l = 0; l < top; l++)
            if (cnt_m[t][l] == 0)
                n++;
        return n;
    endfunction

    // ------------------------------------------------------------------
    // Config stream
    // ------------------------------------------------------------------
    task automatic send_byte(input logic [7:0] data, input logic last, inout int stalls);
        int wait_cyc;
        wait_cyc = 0;
        @(negedge clk_i);
        cfg_valid_i = 1'b1;
        cfg_data_i  = data;
        cfg_last_i  = last;
        while (!cfg_accept_o && wait_cyc < 20)
        begin
            stalls++;
            wait_cyc++;
            @(negedge clk_i);
        end
        if (!cfg_accept_o)
        begin
            $display("Timeout: config byte %02h was never accepted", data);
            err_cnt++;
        end
    endtask

    task automatic load_table(input int t, output int stalls);
        logic [7:0] sel;
        // Class in the high nibble, destination id in the low
        sel    = 8'((t % 2) * 16 + t / 2);
        stalls = 0;
        send_byte(sel, 1'b0, stalls);
        for (int l = 0; l < 16; l++)
            send_byte(8'(cnt_m[t][l]), 1'b0, stalls);
        for (int k = 0; k < nsym_m[t]; k++)
            send_byte(sym_m[t][k], k == nsym_m[t] - 1, stalls);
        @(negedge clk_i);
        cfg_valid_i = 1'b0;
        cfg_last_i  = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Lookups
    // ------------------------------------------------------------------

    // Code left-aligned in the window, random filler below it
    task automatic lookup(input int t, input int k, input bit gap);
        logic [31:0] mask;
        logic [31:0] win;
        mask = (32'd1 << (16 - len_m[t][k])) - 32'd1;
        win  = (32'(code_m[t][k]) << (16 - len_m[t][k])) | (next_rand() & mask);
        @(negedge clk_i);
        lookup_req_i   = 1'b1;
        lookup_table_i = 2'(t);
        lookup_input_i = win[15:0];
        exp_w_q.push_back(5'(len_m[t][k]));
        exp_v_q.push_back(sym_m[t][k]);
        if (gap)
        begin
            @(negedge clk_i);
            lookup_req_i = 1'b0;
        end
    endtask

    task automatic drain();
        int wait_cyc;
        wait_cyc = 0;
        @(negedge clk_i);
        lookup_req_i = 1'b0;
        while (exp_w_q.size() != 0 && wait_cyc < 10)
        begin
            wait_cyc++;
            @(negedge clk_i);
        end
        if (exp_w_q.size() != 0)
        begin
            $display("Timeout: %0d lookup results never arrived", exp_w_q.size());
            err_cnt++;
            exp_w_q.delete();
            exp_v_q.delete();
        end
    endtask

    task automatic check_table(input int t, input bit gap);
        for (int k = 0; k < nsym_m[t]; k++)
            lookup(t, k, gap);
        drain();
    endtask

    // Results leave the queue in request order
    always @(negedge clk_i)
    begin
        if (lookup_valid_o)
        begin
            assert (exp_w_q.size() != 0)
            else
            begin
                $display("Lookup result at %0t ns with no request outstanding", $time);
                err_cnt++;
            end
            if (exp_w_q.size() != 0)
            begin
                assert (lookup_width_o == exp_w_q[0] && lookup_value_o == exp_v_q[0])
                else
                begin
                    $display("ERROR %0t ns: width %0d value %02h, expected %0d %02h", $time,
                             lookup_width_o, lookup_value_o, exp_w_q[0], exp_v_q[0]);
                    err_cnt++;
                end
                void'(exp_w_q.pop_front());
                void'(exp_v_q.pop_front());
            end
        end
    end

    task automatic end_test(input string name);
        int now_err;
        now_err = err_cnt + DUT.u_asserts.fail_cnt;
        tests_run++;
        if (now_err != mark)
            tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (now_err == mark) ? "ok" : "FAILED");
        mark = now_err;
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial
    begin
        int stalls;
        rst_i          = 1'b1;
        cfg_valid_i    = 1'b0;
        cfg_data_i     = '0;
        cfg_last_i     = 1'b0;
        lookup_req_i   = 1'b0;
        lookup_table_i = '0;
        lookup_input_i = '0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        repeat (4)
        begin
            @(negedge clk_i);
            assert (cfg_accept_o && !lookup_valid_o)
            else
            begin
                $display("ERROR %0t ns: accept %b valid %b after reset", $time,
                         cfg_accept_o, lookup_valid_o);
                err_cnt++;
            end
        end
        end_test("reset state");

        make_table(0, 1'b0);
        load_table(0, stalls);
        check_table(0, 1'b1);
        end_test("one table");

        for (int t = 1; t < 4; t++)
        begin
            make_table(t, 1'b0);
            load_table(t, stalls);
        end
        for (int t = 0; t < 4; t++)
            check_table(t, 1'b1);
        end_test("four tables");

        make_table(2, 1'b1);
        load_table(2, stalls);
        assert (stalls == skipped(2))
        else
        begin
            $display("ERROR %0t ns: %0d stall cycles, expected %0d", $time, stalls, skipped(2));
            err_cnt++;
        end
        check_table(2, 1'b1);
        end_test("empty lengths");

        for (int n = 0; n < 40; n++)
        begin
            int t;
            t = int'(next_rand() % 4);
            lookup(t, int'(next_rand() % nsym_m[t]), 1'b0);
        end
        drain();
        end_test("back to back");

        make_table(1, 1'b0);
        load_table(1, stalls);
        for (int t = 0; t < 4; t++)
            check_table(t, 1'b0);
        end_test("reload");

        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, DUT.u_asserts.fail_cnt);
        if (tests_failed == 0 && err_cnt == 0 && DUT.u_asserts.fail_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: vlog.f
hdl/jpeg_dht_pkg.sv
hdl/dht_wr_if.sv
hdl/dht_segment_parser.sv
hdl/dht_code_table.sv
hdl/dht_value_ram.sv
hdl/jpeg_dht.sv
bench/jpeg_dht_asserts.sv
bench/tb_jpeg_dht.sv
